// ==== stopwatch_pkg.sv ====
package stopwatch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // board and display sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int btn_count   = 2;  // start/stop, lap
    localparam int digit_count = 4;

    ////////////////////////////////////////////////////////////////////////////
    // time base and counter ranges
    ////////////////////////////////////////////////////////////////////////////

    localparam int msec_per_csec = 10;

    // defaults for a 100 MHz board clock
    localparam int default_cycles_per_msec  = 100_000;
    localparam int default_debounce_period  = 131_072;  // about 1.3 ms
    localparam int default_scan_period      = 65_536;

    localparam int csec_modulus = 100;  // 00..99
    localparam int sec_modulus  = 60;   // 00..59

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [3:0] bcd_digit_t;

    // one display word
    // t    : time fields, seconds in the upper pair, centiseconds in the lower
    // digit: scan order, index 0 is the rightmost digit
    typedef union packed {
        struct packed {
            bcd_digit_t sec10;
            bcd_digit_t sec1;
            bcd_digit_t csec10;
            bcd_digit_t csec1;
        } t;
        bcd_digit_t [digit_count-1:0] digit;
    } disp_word_u;

endpackage

// ==== button_sync.sv ====
`timescale 1ns/1ps

module button_sync #(
    parameter int debounce_period = stopwatch_pkg::default_debounce_period
) (
    input  logic                                clk,
    input  logic                                reset_p,
    input  logic [stopwatch_pkg::btn_count-1:0] btn,
    output logic [stopwatch_pkg::btn_count-1:0] btn_pedge
);

    import stopwatch_pkg::*;

    logic [$clog2(debounce_period+1)-1:0] div_cnt;
    logic                                 sample_tick;
    logic [btn_count-1:0]                 btn_smp;   // debounced level
    logic [btn_count-1:0]                 btn_prev;

    ////////////////////////////////////////////////////////////////////////////
    // shared sample tick, one cycle in every debounce_period
    ////////////////////////////////////////////////////////////////////////////

    assign sample_tick = (div_cnt == debounce_period - 1);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else if (sample_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // chatter between two ticks is never seen
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            btn_smp <= '0;
        end else if (sample_tick) begin
            btn_smp <= btn;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // rising edge of the sampled level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            btn_prev <= '0;
        end else begin
            btn_prev <= btn_smp;
        end
    end

    assign btn_pedge = btn_smp & ~btn_prev;  // one cycle per press

endmodule

// ==== time_base.sv ====
`timescale 1ns/1ps

module time_base #(
    parameter int cycles_per_msec = stopwatch_pkg::default_cycles_per_msec
) (
    input  logic clk,
    input  logic reset_p,
    input  logic run,
    output logic csec_tick
);

    import stopwatch_pkg::*;

    logic [$clog2(cycles_per_msec+1)-1:0] cyc_cnt;
    logic [$clog2(msec_per_csec+1)-1:0]   msec_cnt;
    logic                                 msec_strobe;

    // both stages freeze while stopped, so a resume picks up mid-interval
    assign msec_strobe = run && (cyc_cnt == cycles_per_msec - 1);
    assign csec_tick   = msec_strobe && (msec_cnt == msec_per_csec - 1);

    // clk -> msec
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cyc_cnt <= '0;
        end else if (msec_strobe) begin
            cyc_cnt <= '0;
        end else if (run) begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // msec -> csec, divide by ten
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            msec_cnt <= '0;
        end else if (csec_tick) begin
            msec_cnt <= '0;
        end else if (msec_strobe) begin
            msec_cnt <= msec_cnt + 1'b1;
        end
    end

endmodule

// ==== bcd_counter.sv ====
`timescale 1ns/1ps

module bcd_counter #(
    parameter int modulus = stopwatch_pkg::csec_modulus  // 60 or 100
) (
    input  logic                      clk,
    input  logic                      reset_p,
    input  logic                      tick_in,
    output stopwatch_pkg::bcd_digit_t dec1,
    output stopwatch_pkg::bcd_digit_t dec10,
    output logic                      carry
);

    import stopwatch_pkg::*;

    logic at_max;
    logic dec1_max;

    // last count is modulus-1, e.g. 59 or 99
    assign at_max = (dec1 == bcd_digit_t'((modulus - 1) % 10)) &&
                    (dec10 == bcd_digit_t'((modulus - 1) / 10));

    assign dec1_max = (dec1 == bcd_digit_t'(9));

    assign carry = tick_in && at_max;  // same cycle as the wrap

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            dec1  <= '0;
            dec10 <= '0;
        end else if (tick_in) begin
            if (at_max) begin
                dec1  <= '0;
                dec10 <= '0;
            end else if (dec1_max) begin
                dec1  <= '0;                  // ones roll into tens
                dec10 <= dec10 + 1'b1;
            end else begin
                dec1  <= dec1 + 1'b1;
            end
        end
    end

endmodule

// ==== stopwatch_ctrl.sv ====
`timescale 1ns/1ps

module stopwatch_ctrl (
    input  logic                      clk,
    input  logic                      reset_p,
    input  logic                      start_pedge,
    input  logic                      lap_pedge,
    input  stopwatch_pkg::disp_word_u cur_time,
    output logic                      run,
    output stopwatch_pkg::disp_word_u disp_value
);

    import stopwatch_pkg::*;

    logic       lap_mode;
    logic       lap_load;
    disp_word_u lap_time;

    ////////////////////////////////////////////////////////////////////////////
    // toggles
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            run <= 1'b0;
        end else if (start_pedge) begin
            run <= ~run;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            lap_mode <= 1'b0;
        end else if (lap_pedge) begin
            lap_mode <= ~lap_mode;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lap capture
    ////////////////////////////////////////////////////////////////////////////

    // only on entering lap, the exit press leaves the held value alone
    assign lap_load = lap_pedge && !lap_mode;

    always_ff @(posedge clk) begin
        if (lap_load) begin
            lap_time <= cur_time;
        end
    end

    // counters keep running underneath a frozen lap display
    assign disp_value = lap_mode ? lap_time : cur_time;

endmodule

// ==== fnd_scan.sv ====
`timescale 1ns/1ps

module fnd_scan #(
    parameter int scan_period = stopwatch_pkg::default_scan_period
) (
    input  logic                                  clk,
    input  logic                                  reset_p,
    input  stopwatch_pkg::disp_word_u             value,
    output logic [stopwatch_pkg::digit_count-1:0] com,
    output logic [7:0]                            seg_7
);

    import stopwatch_pkg::*;

    logic [$clog2(scan_period+1)-1:0] scan_cnt;
    logic                             scan_step;
    logic [$clog2(digit_count)-1:0]   digit_sel;
    bcd_digit_t                       digit_q;
    logic [6:0]                       seg_on;   // g..a, 1 = lit

    ////////////////////////////////////////////////////////////////////////////
    // digit ring
    ////////////////////////////////////////////////////////////////////////////

    assign scan_step = (scan_cnt == scan_period - 1);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt <= '0;
        end else if (scan_step) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // active low one-hot, 1110 -> 1101 -> 1011 -> 0111
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            com <= {{(digit_count-1){1'b1}}, 1'b0};
        end else if (scan_step) begin
            com <= {com[digit_count-2:0], com[digit_count-1]};
        end
    end

    // position of the low bit
    always_comb begin
        digit_sel = '0;
        for (int i = 0; i < digit_count; i++) begin
            if (!com[i]) digit_sel = i[$clog2(digit_count)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        digit_q <= value.digit[digit_sel];  // lags com by one cycle
    end

    ////////////////////////////////////////////////////////////////////////////
    // segment decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (digit_q)
            4'd0:    seg_on = 7'b0111111;
            4'd1:    seg_on = 7'b0000110;
            4'd2:    seg_on = 7'b1011011;
            4'd3:    seg_on = 7'b1001111;
            4'd4:    seg_on = 7'b1100110;
            4'd5:    seg_on = 7'b1101101;
            4'd6:    seg_on = 7'b1111101;
            4'd7:    seg_on = 7'b0000111;
            4'd8:    seg_on = 7'b1111111;
            4'd9:    seg_on = 7'b1101111;
            default: seg_on = 7'b0000000;  // not BCD, blank
        endcase
    end

    // common anode, dp kept dark
    assign seg_7 = ~{1'b0, seg_on};

endmodule

// ==== stopwatch_top.sv ====
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int cycles_per_msec = stopwatch_pkg::default_cycles_per_msec,
    parameter int debounce_period = stopwatch_pkg::default_debounce_period,
    parameter int scan_period     = stopwatch_pkg::default_scan_period
) (
    input  logic                                clk,
    input  logic                                reset_p,
    input  logic [stopwatch_pkg::btn_count-1:0] btn,      // 0 start/stop, 1 lap
    output logic [3:0]                          com,
    output logic [7:0]                          seg_7
);

    import stopwatch_pkg::*;

    logic [btn_count-1:0] btn_pedge;
    logic                 run;
    logic                 csec_tick;
    logic                 csec_carry;
    bcd_digit_t           csec1;
    bcd_digit_t           csec10;
    bcd_digit_t           sec1;
    bcd_digit_t           sec10;
    disp_word_u           cur_time;
    disp_word_u           disp_value;

    button_sync #(.debounce_period(debounce_period)) u_button_sync (
        .clk       (clk),
        .reset_p   (reset_p),
        .btn       (btn),
        .btn_pedge (btn_pedge)
    );

    time_base #(.cycles_per_msec(cycles_per_msec)) u_time_base (
        .clk       (clk),
        .reset_p   (reset_p),
        .run       (run),
        .csec_tick (csec_tick)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ss.cc counter chain
    ////////////////////////////////////////////////////////////////////////////

    bcd_counter #(.modulus(csec_modulus)) u_csec (
        .clk     (clk),
        .reset_p (reset_p),
        .tick_in (csec_tick),
        .dec1    (csec1),
        .dec10   (csec10),
        .carry   (csec_carry)
    );

    bcd_counter #(.modulus(sec_modulus)) u_sec (
        .clk     (clk),
        .reset_p (reset_p),
        .tick_in (csec_carry),
        .dec1    (sec1),
        .dec10   (sec10),
        .carry   ()                 // no minute stage
    );

    assign cur_time.t = {sec10, sec1, csec10, csec1};

    stopwatch_ctrl u_ctrl (
        .clk         (clk),
        .reset_p     (reset_p),
        .start_pedge (btn_pedge[0]),
        .lap_pedge   (btn_pedge[1]),
        .cur_time    (cur_time),
        .run         (run),
        .disp_value  (disp_value)
    );

    fnd_scan #(.scan_period(scan_period)) u_fnd (
        .clk     (clk),
        .reset_p (reset_p),
        .value   (disp_value),
        .com     (com),
        .seg_7   (seg_7)
    );

endmodule

// ==== tb_stopwatch.sv ====
`timescale 1ns/1ps

module tb_stopwatch;

    localparam int cycles_per_msec = 2;
    localparam int debounce_period = 4;
    localparam int scan_period     = 8;
    localparam int csec_cycles     = cycles_per_msec * 10;  // 20 clk per csec
    localparam int reset_cycles    = 8;
    localparam int read_allow      = 300;  // worst case for one display read
    localparam int margin_cycles   = 2000;

    // button column
    localparam int btn_start = 0;
    localparam int btn_lap   = 1;
    localparam int btn_idle  = 2;

    // check column
    localparam int chk_none  = 0;
    localparam int chk_zero  = 1;  // display reads 00.00
    localparam int chk_count = 2;  // frozen display vs elapsed run time
    localparam int chk_hold  = 3;  // frozen display vs last read value

    localparam int n_rows = 12;

    typedef struct {
        int button;
        int hold;
        int wait_min;
        int wait_max;
        int kind;
    } row_t;

    logic       clk;
    logic       reset_p;
    logic [1:0] btn;
    logic [3:0] com;
    logic [7:0] seg_7;

    row_t        rows [n_rows];
    bit          table_ready = 1'b0;
    bit          run_model   = 1'b0;  // what run should be after the last press
    int          run_cycles  = 0;
    int          press_snapshot = 0;
    int          held = 0;

    stopwatch_top #(
        .cycles_per_msec (cycles_per_msec),
        .debounce_period (debounce_period),
        .scan_period     (scan_period)
    ) u_dut (
        .clk     (clk),
        .reset_p (reset_p),
        .btn     (btn),
        .com     (com),
        .seg_7   (seg_7)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference run time, counted away from the drive edge
    always @(negedge clk) begin
        if (run_model) run_cycles <= run_cycles + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input int expected, input int actual,
                               input int tol);
        if (actual < expected - tol || actual > expected + tol) begin
            $display("FAIL t=%0t %s expected %0d (+/-%0d) actual %0d",
                     $time, name, expected, tol, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // common anode patterns, dp dark
    function automatic int seg_to_digit(input logic [7:0] seg);
        case (seg)
            8'hc0:   return 0;
            8'hf9:   return 1;
            8'ha4:   return 2;
            8'hb0:   return 3;
            8'h99:   return 4;
            8'h92:   return 5;
            8'h82:   return 6;
            8'hf8:   return 7;
            8'h80:   return 8;
            8'h90:   return 9;
            default: return -1;
        endcase
    endfunction

    // one pass over the ring, digit 0 first, result as decimal ss cc
    task automatic read_display(output int total, output int sec10);
        int         digit [4];
        logic [3:0] pat;
        int         d;
        for (int i = 0; i < 4; i++) begin
            pat = ~(4'b0001 << i);
            @(negedge clk);
            while (com == pat) @(negedge clk);  // catch the fresh edge of pat
            while (com != pat) @(negedge clk);
            repeat (2) @(negedge clk);           // digit register lags com
            d = seg_to_digit(seg_7);
            if (d < 0) begin
                $display("unknown segment pattern %b while com is %b", seg_7, com);
                $display("TEST FAIL");
                $fatal(1, "display could not be decoded");
            end
            digit[i] = d;
        end
        total = digit[3] * 1000 + digit[2] * 100 + digit[1] * 10 + digit[0];
        sec10 = digit[3];
    endtask

    task automatic press_button(input int idx, input int hold);
        @(posedge clk);
        btn[idx] <= 1'b1;
        if (idx == btn_start) run_model = !run_model;
        press_snapshot = run_cycles;  // lap capture or stop point
        repeat (hold) @(posedge clk);
        btn[idx] <= 1'b0;
    endtask

    task automatic load_rows();
        rows[0]  = '{btn_idle,  0,    16,    16, chk_zero};
        rows[1]  = '{btn_idle,  0, 10000, 10000, chk_zero};   // idle, not running
        rows[2]  = '{btn_start, 8,  3000,  5000, chk_none};   // start
        rows[3]  = '{btn_start, 8,   100,   100, chk_count};  // stop
        rows[4]  = '{btn_idle,  0,  5000,  5000, chk_hold};
        rows[5]  = '{btn_start, 8,  2500,  8000, chk_none};   // resume, past a wrap
        rows[6]  = '{btn_start, 8,   100,   100, chk_count};
        rows[7]  = '{btn_start, 8,  2000,  4000, chk_none};
        rows[8]  = '{btn_lap,   8,   100,   100, chk_count};  // lap value L
        rows[9]  = '{btn_idle,  0,  3000,  3000, chk_hold};   // still L
        rows[10] = '{btn_lap,   8,  1000,  3000, chk_none};   // back to live
        rows[11] = '{btn_start, 8,   100,   100, chk_count};
    endtask

    function automatic int cycle_budget();
        int sum;
        sum = reset_cycles;
        for (int r = 0; r < n_rows; r++) begin
            sum = sum + rows[r].hold + 1 + rows[r].wait_max + read_allow;
        end
        return sum + margin_cycles;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // watchdog and main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        int budget;
        wait (table_ready);
        budget = cycle_budget();
        repeat (budget) @(posedge clk);
        $display("timeout, the test table did not finish within %0d cycles", budget);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int          w;
        int unsigned span;
        int          total;
        int          s10;
        btn       = '0;
        reset_p   = 1'b1;
        void'($urandom(32'h533));
        load_rows();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        reset_p <= 1'b0;
        @(negedge clk);
        check_value("com", 4'b1110, int'(com), 0);

        for (int r = 0; r < n_rows; r++) begin
            if (rows[r].button != btn_idle) press_button(rows[r].button, rows[r].hold);
            span = rows[r].wait_max - rows[r].wait_min + 1;
            w = rows[r].wait_min + int'($urandom % span);
            repeat (w) @(posedge clk);
            case (rows[r].kind)
                chk_zero: begin
                    read_display(total, s10);
                    check_value("display", 0, total, 0);
                end
                chk_count: begin
                    read_display(total, s10);
                    check_value("sec10_le_5", 1, int'(s10 <= 5), 0);
                    // ss*100 + cc against whole csec periods of run
                    check_value("elapsed_csec", press_snapshot / csec_cycles, total, 2);
                    held = total;
                end
                chk_hold: begin
                    read_display(total, s10);
                    check_value("display", held, total, 0);
                end
                default: ;
            endcase
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
stopwatch_pkg.sv
button_sync.sv
time_base.sv
bcd_counter.sv
stopwatch_ctrl.sv
fnd_scan.sv
stopwatch_top.sv
tb_stopwatch.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the stopwatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_stopwatch -o tb_stopwatch
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_stopwatch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
